//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_hdc_encoder
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Output is kept in a shell variable and searched for the pass line
run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
hw/hdc_pkg.sv
hw/map_fsm.sv
hw/item_memory.sv
hw/bind_bundle.sv
hw/segment_buffer.sv
hw/hdc_encoder_top.sv
tb/tb_hdc_encoder.sv

//--- hw/bind_bundle.sv
`timescale 1ns/1ps

module bind_bundle #(
    parameter int N_CHANNELS = 3
) (
    input  hdc_pkg::bound_segs_t segs,
    output hdc_pkg::hv_seg_t     seg,
    output logic                 seg_valid,
    output hdc_pkg::seg_ctr_t    seg_idx
);

    localparam int CNT_WIDTH = $clog2(N_CHANNELS + 1);

    hdc_pkg::hv_seg_t [N_CHANNELS-1:0] bound;

    // Binding
    always_comb begin
        for (int c = 0; c < N_CHANNELS; c++) begin
            bound[c] = segs.pairs[c].id_seg ^ segs.pairs[c].lvl_seg;
        end
    end

    // Bitwise majority over channels
    always_comb begin : majority
        logic [CNT_WIDTH-1:0] ones;
        ones = '0;
        for (int b = 0; b < hdc_pkg::SEG_WIDTH; b++) begin
            ones = '0;
            for (int c = 0; c < N_CHANNELS; c++) begin
                ones = ones + CNT_WIDTH'(bound[c][b]);
            end
            seg[b] = (ones > CNT_WIDTH'(N_CHANNELS / 2));
        end
    end

    assign seg_valid = segs.valid;
    assign seg_idx   = segs.idx;

endmodule

//--- hw/hdc_encoder_top.sv
`timescale 1ns/1ps

module hdc_encoder_top #(
    parameter int N_CHANNELS = 3    // Odd so majority has no ties
) (
    input  logic                             clk,
    input  logic                             nrst,
    input  logic                             en,
    input  logic                             start_mapping,
    input  hdc_pkg::level_t [N_CHANNELS-1:0] features,
    output hdc_pkg::hv_t                     hv,
    output logic                             mapping_done,
    output logic                             mapping_hv_segment
);

    hdc_pkg::seg_ctr_t    ctr;
    hdc_pkg::bound_segs_t segs;
    hdc_pkg::hv_seg_t     seg;
    logic                 seg_valid;
    hdc_pkg::seg_ctr_t    seg_idx;

    map_fsm u_map_fsm (
        .clk                (clk),
        .nrst               (nrst),
        .en                 (en),
        .start_mapping      (start_mapping),
        .ctr                (ctr),
        .mapping_hv_segment (mapping_hv_segment),
        .mapping_done       (mapping_done)
    );

    item_memory #(
        .N_CHANNELS (N_CHANNELS)
    ) u_item_memory (
        .clk                (clk),
        .nrst               (nrst),
        .ctr                (ctr),
        .mapping_hv_segment (mapping_hv_segment),
        .features           (features),
        .segs               (segs)
    );

    bind_bundle #(
        .N_CHANNELS (N_CHANNELS)
    ) u_bind_bundle (
        .segs      (segs),
        .seg       (seg),
        .seg_valid (seg_valid),
        .seg_idx   (seg_idx)
    );

    segment_buffer u_segment_buffer (
        .clk       (clk),
        .nrst      (nrst),
        .seg       (seg),
        .seg_valid (seg_valid),
        .seg_idx   (seg_idx),
        .hv        (hv)
    );

endmodule

//--- hw/hdc_pkg.sv
package hdc_pkg;

    localparam int SEG_WIDTH       = 32;
    localparam int SEQ_CYCLE_COUNT = 16;
    localparam int CTR_WIDTH       = 4;
    localparam int HV_WIDTH        = SEG_WIDTH * SEQ_CYCLE_COUNT;
    localparam int LEVEL_WIDTH     = 4;
    localparam int MAX_CHANNELS    = 7;     // Upper bound for N_CHANNELS

    typedef logic [SEG_WIDTH-1:0]   hv_seg_t;
    typedef hv_seg_t [SEQ_CYCLE_COUNT-1:0] hv_t;   // Segment k at bits k*32 +: 32
    typedef logic [LEVEL_WIDTH-1:0] level_t;
    typedef logic [CTR_WIDTH-1:0]   seg_ctr_t;

    // One seed word per segment index
    localparam hv_seg_t SEG_SEEDS [SEQ_CYCLE_COUNT] = '{
        32'h9E3779B9, 32'h7F4A7C15, 32'hC2B2AE35, 32'h165667B1,
        32'h27D4EB2F, 32'h85EBCA77, 32'hD3A2646C, 32'hFD7046C5,
        32'hB55A4F09, 32'h6C8E9CF5, 32'h4CF5AD43, 32'h2545F491,
        32'hE7037ED1, 32'h8EBC6AF0, 32'h589965CC, 32'h1D8E4E27
    };

    typedef struct packed {
        hv_seg_t id_seg;
        hv_seg_t lvl_seg;
    } seg_pair_t;

    // Channels at or above N_CHANNELS stay zero
    typedef struct packed {
        logic                               valid;
        seg_ctr_t                           idx;
        seg_pair_t [MAX_CHANNELS-1:0]       pairs;
    } bound_segs_t;

    // Rotate left by an amount taken modulo the segment width
    function automatic hv_seg_t rotl(input hv_seg_t x, input int unsigned n);
        int unsigned s;
        s = n % SEG_WIDTH;
        return (x << s) | (x >> (SEG_WIDTH - s));
    endfunction

endpackage

//--- hw/item_memory.sv
`timescale 1ns/1ps

module item_memory #(
    parameter int N_CHANNELS = 3
) (
    input  logic                               clk,
    input  logic                               nrst,
    input  hdc_pkg::seg_ctr_t                  ctr,
    input  logic                               mapping_hv_segment,
    input  hdc_pkg::level_t [N_CHANNELS-1:0]   features,
    output hdc_pkg::bound_segs_t               segs
);

    hdc_pkg::hv_seg_t                                  seed;
    hdc_pkg::seg_pair_t [hdc_pkg::MAX_CHANNELS-1:0]    pairs_d;
    hdc_pkg::seg_pair_t [hdc_pkg::MAX_CHANNELS-1:0]    pairs_q;
    logic                                              valid_q;
    hdc_pkg::seg_ctr_t                                 idx_q;

    assign seed = hdc_pkg::SEG_SEEDS[ctr];

    // Identity by channel rotation, level by rotation of the inverted seed
    always_comb begin
        pairs_d = '0;
        for (int c = 0; c < N_CHANNELS; c++) begin
            pairs_d[c].id_seg  = hdc_pkg::rotl(seed, 16 + c);
            pairs_d[c].lvl_seg = hdc_pkg::rotl(~seed, features[c]);
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            valid_q <= 1'b0;
            idx_q   <= '0;
        end else begin
            valid_q <= mapping_hv_segment;
            idx_q   <= ctr;
        end
    end

    always_ff @(posedge clk) begin
        pairs_q <= pairs_d;
    end

    always_comb begin
        segs.valid = valid_q;
        segs.idx   = idx_q;
        segs.pairs = pairs_q;
    end

endmodule

//--- hw/map_fsm.sv
`timescale 1ns/1ps

module map_fsm (
    input  logic              clk,
    input  logic              nrst,
    input  logic              en,
    input  logic              start_mapping,
    output hdc_pkg::seg_ctr_t ctr,
    output logic              mapping_hv_segment,
    output logic              mapping_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_MAP,
        S_BUFFER,
        S_MAP_DONE
    } state_t;

    state_t state;
    logic   hv_fetch_done;

    // Last segment addressed this cycle
    assign hv_fetch_done = (ctr == hdc_pkg::seg_ctr_t'(hdc_pkg::SEQ_CYCLE_COUNT - 1));

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_mapping && en) begin
                        state <= S_MAP;
                    end
                end
                S_MAP: begin
                    if (hv_fetch_done) begin
                        state <= S_BUFFER;  // Let the pipeline drain
                    end
                end
                S_BUFFER: begin
                    state <= S_MAP_DONE;
                end
                default: begin
                    // Back to back start skips IDLE
                    if (start_mapping && en) begin
                        state <= S_MAP;
                    end else begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_comb begin
        case (state)
            S_MAP:      {mapping_hv_segment, mapping_done} = 2'b10;
            S_MAP_DONE: {mapping_hv_segment, mapping_done} = 2'b01;
            default:    {mapping_hv_segment, mapping_done} = 2'b00;
        endcase
    end

    // Segment select that restarts whenever en drops in MAP
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ctr <= '0;
        end else if ((state == S_MAP) && en) begin
            ctr <= ctr + hdc_pkg::seg_ctr_t'(1);
        end else begin
            ctr <= '0;
        end
    end

endmodule

//--- hw/segment_buffer.sv
`timescale 1ns/1ps

module segment_buffer (
    input  logic              clk,
    input  logic              nrst,
    input  hdc_pkg::hv_seg_t  seg,
    input  logic              seg_valid,
    input  hdc_pkg::seg_ctr_t seg_idx,
    output hdc_pkg::hv_t      hv
);

    // Overwrites one slot per valid segment and holds between sweeps
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            hv <= '0;
        end else if (seg_valid) begin
            hv[seg_idx] <= seg;
        end
    end

endmodule

//--- tb/tb_hdc_encoder.sv
`timescale 1ns/1ps

module tb_hdc_encoder;

    localparam int N_CHANNELS   = 3;
    localparam int DONE_EDGES   = 18;   // Rising edges from the start edge up to mapping_done
    localparam int DONE_TIMEOUT = 100;
    localparam int IDLE_CYCLES  = 30;
    localparam int RANDOM_RUNS  = 10;
    localparam int DROP_AT      = 6;
    localparam int DROP_LEN     = 3;

    typedef hdc_pkg::level_t [N_CHANNELS-1:0] feat_t;

    logic         clk;
    logic         nrst;
    logic         en;
    logic         start_mapping;
    feat_t        features;
    hdc_pkg::hv_t hv;
    logic         mapping_done;
    logic         mapping_hv_segment;

    int seed = 49;
    int errors;
    int checks;
    int tests_run;
    int tests_failed;

    hdc_encoder_top #(
        .N_CHANNELS (N_CHANNELS)
    ) dut_i (
        .clk                (clk),
        .nrst               (nrst),
        .en                 (en),
        .start_mapping      (start_mapping),
        .features           (features),
        .hv                 (hv),
        .mapping_done       (mapping_done),
        .mapping_hv_segment (mapping_hv_segment)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Upper half of the doubled word is the rotated value
    function automatic hdc_pkg::hv_seg_t rot_left(input hdc_pkg::hv_seg_t x, input int n);
        logic [2*hdc_pkg::SEG_WIDTH-1:0] d;
        d = {x, x} << (n % hdc_pkg::SEG_WIDTH);
        return d[2*hdc_pkg::SEG_WIDTH-1 -: hdc_pkg::SEG_WIDTH];
    endfunction

    // Expected hypervector from the mapping rules
    function automatic hdc_pkg::hv_t ref_hv(input feat_t f);
        hdc_pkg::hv_t     h;
        hdc_pkg::hv_seg_t seed_k;
        hdc_pkg::hv_seg_t bound [N_CHANNELS];
        int               ones;
        h = '0;
        for (int k = 0; k < hdc_pkg::SEQ_CYCLE_COUNT; k++) begin
            seed_k = hdc_pkg::SEG_SEEDS[k];
            for (int c = 0; c < N_CHANNELS; c++) begin
                bound[c] = rot_left(seed_k, 16 + c) ^ rot_left(~seed_k, int'(f[c]));
            end
            for (int b = 0; b < hdc_pkg::SEG_WIDTH; b++) begin
                ones = 0;
                for (int c = 0; c < N_CHANNELS; c++) begin
                    ones += int'(bound[c][b]);
                end
                h[k][b] = (2 * ones > N_CHANNELS);  // More than half
            end
        end
        return h;
    endfunction

    task automatic random_features(output feat_t f);
        for (int c = 0; c < N_CHANNELS; c++) begin
            f[c] = hdc_pkg::level_t'($random(seed));
        end
    endtask

    task automatic check_hv(input hdc_pkg::hv_t got, input hdc_pkg::hv_t exp, input string what);
        int bad;
        bad = -1;
        checks++;
        for (int k = hdc_pkg::SEQ_CYCLE_COUNT - 1; k >= 0; k--) begin
            if (got[k] !== exp[k]) begin
                bad = k;    // Lowest differing segment
            end
        end
        if (bad >= 0) begin
            errors++;
            $display("FAILED at %0t ns: %s, segment %0d is %h, expected %h",
                     $time, what, bad, got[bad], exp[bad]);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", name, errors - errors_before);
        end
    endtask

    task automatic do_reset();
        nrst = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
    endtask

    // Call on a falling edge so the next rising edge samples the strobe
    task automatic start_sweep(input feat_t f);
        features      = f;
        start_mapping = 1'b1;
    endtask

    // Returns on the falling edge where mapping_done is seen
    task automatic wait_done(input int drop_at, input int drop_len, output int edges,
                             output int seg_cycles, output bit seen);
        edges      = 0;
        seg_cycles = 0;
        seen       = 1'b0;
        while (!seen && edges < DONE_TIMEOUT) begin
            @(negedge clk);
            edges++;
            if (mapping_hv_segment) begin
                seg_cycles++;
            end
            seen          = mapping_done;
            start_mapping = 1'b0;
            if (drop_len > 0 && edges == drop_at) begin
                en = 1'b0;
            end
            if (drop_len > 0 && edges == drop_at + drop_len) begin
                en = 1'b1;
            end
        end
        if (!seen) begin
            errors++;
            $display("Timeout: mapping_done did not arrive within %0d cycles", DONE_TIMEOUT);
        end
    endtask

    task automatic test_reset();
        int errs;
        errs = errors;
        do_reset();
        check_bit(mapping_done, 1'b0, "mapping_done after reset");
        check_bit(mapping_hv_segment, 1'b0, "mapping_hv_segment after reset");
        check_hv(hv, '0, "hv after reset");
        report_test("reset state", errs);
    endtask

    task automatic test_fixed();
        int    errs;
        int    edges;
        int    seg_cycles;
        bit    seen;
        feat_t f;
        errs = errors;
        f    = '0;
        en   = 1'b1;
        start_sweep(f);
        wait_done(0, 0, edges, seg_cycles, seen);
        if (seen) begin
            check_bit(edges == DONE_EDGES, 1'b1, $sformatf("latency of %0d edges", edges));
            check_bit(seg_cycles == hdc_pkg::SEQ_CYCLE_COUNT, 1'b1,
                      $sformatf("mapping_hv_segment high for %0d cycles", seg_cycles));
            check_hv(hv, ref_hv(f), "hv for all levels 0");
            @(negedge clk);
            check_bit(mapping_done, 1'b0, "mapping_done one cycle wide");
        end
        report_test("fixed encoding and latency", errs);
    endtask

    task automatic test_random();
        int    errs;
        int    edges;
        int    seg_cycles;
        bit    seen;
        feat_t f;
        errs = errors;
        for (int i = 0; i < RANDOM_RUNS; i++) begin
            if (i % 2 == 0) begin
                repeat (2) @(negedge clk);  // Back in IDLE
            end
            random_features(f);
            start_sweep(f);
            wait_done(0, 0, edges, seg_cycles, seen);
            if (seen) begin
                check_bit(edges == DONE_EDGES, 1'b1,
                          $sformatf("sweep %0d latency of %0d edges", i, edges));
                check_hv(hv, ref_hv(f), $sformatf("hv of random sweep %0d", i));
            end
        end
        report_test("random features", errs);
    endtask

    task automatic test_en_gating();
        int           errs;
        logic         active;
        hdc_pkg::hv_t hv_before;
        errs          = errors;
        active        = 1'b0;
        hv_before     = hv;
        en            = 1'b0;
        start_mapping = 1'b1;
        @(negedge clk);
        start_mapping = 1'b0;
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            if (mapping_hv_segment || mapping_done) begin
                active = 1'b1;
            end
            @(negedge clk);
        end
        check_bit(active, 1'b0, "sweep activity with en low");
        check_hv(hv, hv_before, "hv with en low");
        en = 1'b1;
        report_test("enable gating of start", errs);
    endtask

    task automatic test_en_drop();
        int    errs;
        int    edges;
        int    seg_cycles;
        bit    seen;
        feat_t f;
        errs = errors;
        random_features(f);
        start_sweep(f);
        wait_done(DROP_AT, DROP_LEN, edges, seg_cycles, seen);
        if (seen) begin
            // Last edge with en low leaves ctr at 0 just like a start edge
            check_bit(edges == DONE_EDGES + DROP_AT + DROP_LEN - 1, 1'b1,
                      $sformatf("sweep restart, done after %0d edges", edges));
            check_hv(hv, ref_hv(f), "hv after en drop");
        end
        report_test("enable dropped mid-sweep", errs);
    endtask

    task automatic test_distinct();
        int           errs;
        int           edges;
        int           seg_cycles;
        bit           seen;
        feat_t        fa;
        feat_t        fb;
        hdc_pkg::hv_t hv_a;
        errs = errors;
        random_features(fa);
        fb    = fa;
        fb[1] = fa[1] + hdc_pkg::level_t'(1);
        start_sweep(fa);
        wait_done(0, 0, edges, seg_cycles, seen);
        hv_a = hv;
        check_hv(hv_a, ref_hv(fa), "hv of first feature set");
        start_sweep(fb);
        wait_done(0, 0, edges, seg_cycles, seen);
        check_hv(hv, ref_hv(fb), "hv of second feature set");
        check_bit(hv != hv_a, 1'b1, "hv differs for one changed channel");
        report_test("channel distinctness", errs);
    endtask

    initial begin
        nrst          = 1'b0;
        en            = 1'b0;
        start_mapping = 1'b0;
        features      = '0;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        tests_failed  = 0;

        test_reset();
        test_fixed();
        test_random();
        test_en_gating();
        test_en_drop();
        test_distinct();

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
